// File: common/render_defs.svh
`ifndef RENDER_DEFS_SVH
`define RENDER_DEFS_SVH

// screen geometry
`define SCREEN_W 320
`define SCREEN_H 240
`define CENTRE_X 160
`define CENTRE_Y 120

// orthographic projection, model units per pixel
`define PROJ_SHIFT 3

// small-angle rotation matrix, scaled by 2^ROT_SHIFT
`define ROT_SHIFT 9
`define ROT_MAJOR 511
`define ROT_XY 10
`define ROT_YZ 5
`define ROT_ONE 512

// number formats and table sizes
`define COORD_W 16
`define PIX_W 9
`define MAX_VERTS 6
`define MAX_EDGES 12

// vertex radii of the two solids
`define TETRA_R 320
`define OCTA_R 480

`endif

// File: common/renderPkg.sv
`include "render_defs.svh"

package renderPkg;

    // one signed model-space component
    typedef logic signed [`COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    // screen coordinate after projection
    typedef logic [`PIX_W-1:0] pixel_t;

    typedef struct packed {
        pixel_t x;
        pixel_t y;
    } point_t;

    typedef logic [$clog2(`MAX_VERTS)-1:0] vertIdx_t;
    typedef logic [$clog2(`MAX_EDGES)-1:0] edgeIdx_t;

    // pair of bank indices
    typedef struct packed {
        vertIdx_t head;
        vertIdx_t tail;
    } edge_t;

    typedef enum logic [1:0] {
        SHAPE_TETRA = 2'd0,
        SHAPE_OCTA  = 2'd1
    } shape_e;

    typedef logic [2:0] colour_t;

endpackage

// File: common/lineReqIf.sv
`timescale 1ns/1ps

// one line request and its completion pulse
interface lineReqIf
    import renderPkg::*;
();
    logic   go;
    point_t startPt;
    point_t endPt;
    logic   done;

    // endpoints stay stable from go until done
    modport sequencer (
        output go,
        output startPt,
        output endPt,
        input  done
    );

    modport rasterizer (
        input  go,
        input  startPt,
        input  endPt,
        output done
    );
endinterface

// File: source/shapeLibrary.sv
`timescale 1ns/1ps
`include "render_defs.svh"

module shapeLibrary
    import renderPkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic [1:0] shapeSelect,
    input  colour_t  colourIn,
    input  logic     frameStart,
    input  vertIdx_t vertIdx,
    input  edgeIdx_t edgeIdx,
    output shape_e   shape,
    output colour_t  colour,
    output vertex_t  baseVertex,
    output edge_t    curEdge,
    output edgeIdx_t lastEdge
);
    localparam coord_t TETRA_RAD = coord_t'(`TETRA_R);
    localparam coord_t OCTA_RAD = coord_t'(`OCTA_R);
    localparam edgeIdx_t TETRA_LAST = edgeIdx_t'(5);
    localparam edgeIdx_t OCTA_LAST = edgeIdx_t'(`MAX_EDGES - 1);

    // alternate corners of a cube
    localparam vertex_t TETRA_VERTS [`MAX_VERTS] = '{
        '{TETRA_RAD, TETRA_RAD, TETRA_RAD}, '{TETRA_RAD, -TETRA_RAD, -TETRA_RAD},
        '{-TETRA_RAD, TETRA_RAD, -TETRA_RAD}, '{-TETRA_RAD, -TETRA_RAD, TETRA_RAD},
        '0, '0
    };

    // +x, -x, +y, -y, +z, -z
    localparam vertex_t OCTA_VERTS [`MAX_VERTS] = '{
        '{OCTA_RAD, 0, 0}, '{-OCTA_RAD, 0, 0}, '{0, OCTA_RAD, 0},
        '{0, -OCTA_RAD, 0}, '{0, 0, OCTA_RAD}, '{0, 0, -OCTA_RAD}
    };

    localparam edge_t TETRA_EDGES [`MAX_EDGES] = '{
        '{3'd0, 3'd1}, '{3'd0, 3'd2}, '{3'd0, 3'd3},
        '{3'd1, 3'd2}, '{3'd1, 3'd3}, '{3'd2, 3'd3},
        '0, '0, '0, '0, '0, '0
    };

    // every pair except opposite poles
    localparam edge_t OCTA_EDGES [`MAX_EDGES] = '{
        '{3'd0, 3'd2}, '{3'd0, 3'd3}, '{3'd0, 3'd4}, '{3'd0, 3'd5},
        '{3'd1, 3'd2}, '{3'd1, 3'd3}, '{3'd1, 3'd4}, '{3'd1, 3'd5},
        '{3'd2, 3'd4}, '{3'd2, 3'd5}, '{3'd3, 3'd4}, '{3'd3, 3'd5}
    };

    always_ff @(posedge clk) begin
        if (!resetn) begin
            shape <= SHAPE_TETRA;
        end else if (frameStart) begin
            // 2 and 3 fall back to the tetrahedron
            shape <= (shapeSelect == 2'd1) ? SHAPE_OCTA : SHAPE_TETRA;
        end
    end

    always_ff @(posedge clk) begin
        if (frameStart) begin
            colour <= colourIn;
        end
    end

    always_comb begin
        if (shape == SHAPE_OCTA) begin
            baseVertex = OCTA_VERTS[vertIdx];
            curEdge = OCTA_EDGES[edgeIdx];
            lastEdge = OCTA_LAST;
        end else begin
            baseVertex = TETRA_VERTS[vertIdx];
            curEdge = TETRA_EDGES[edgeIdx];
            lastEdge = TETRA_LAST;
        end
    end
endmodule

// File: source/vertexRotator.sv
`timescale 1ns/1ps
`include "render_defs.svh"

module vertexRotator
    import renderPkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     load,
    input  logic     rotate,
    input  vertex_t  baseVertex,
    input  edge_t    curEdge,
    output vertIdx_t loadIdx,
    output point_t   startPt,
    output point_t   endPt
);
    vertex_t bank [`MAX_VERTS];

    // fixed small-angle step about z then x, arithmetic shift back to model scale
    function automatic vertex_t rotateVertex(vertex_t v);
        int      x;
        int      y;
        int      z;
        vertex_t r;
        x = int'(v.x);
        y = int'(v.y);
        z = int'(v.z);
        r.x = coord_t'((`ROT_MAJOR * x - `ROT_XY * y) >>> `ROT_SHIFT);
        r.y = coord_t'((`ROT_XY * x + `ROT_MAJOR * y - `ROT_YZ * z) >>> `ROT_SHIFT);
        r.z = coord_t'((x + `ROT_YZ * y + `ROT_ONE * z) >>> `ROT_SHIFT);
        return r;
    endfunction

    function automatic point_t project(vertex_t v);
        coord_t sx;
        coord_t sy;
        point_t p;
        sx = (v.x >>> `PROJ_SHIFT) + coord_t'(`CENTRE_X);
        sy = (v.y >>> `PROJ_SHIFT) + coord_t'(`CENTRE_Y);
        p.x = sx[`PIX_W-1:0];
        p.y = sy[`PIX_W-1:0];
        return p;
    endfunction

    // wraps after the last slot so every reload begins at zero
    always_ff @(posedge clk) begin
        if (!resetn) begin
            loadIdx <= '0;
        end else if (load) begin
            loadIdx <= (loadIdx == vertIdx_t'(`MAX_VERTS - 1)) ? '0 : loadIdx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rotate) begin
            for (int i = 0; i < `MAX_VERTS; i++) begin
                bank[i] <= rotateVertex(bank[i]);
            end
        end else if (load) begin
            bank[loadIdx] <= baseVertex;
        end
    end

    assign startPt = project(bank[curEdge.head]);
    assign endPt = project(bank[curEdge.tail]);
endmodule

// File: source/edgeSequencer.sv
`timescale 1ns/1ps
`include "render_defs.svh"

module edgeSequencer
    import renderPkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  shape_e   shape,
    input  edgeIdx_t lastEdge,
    input  point_t   startPt,
    input  point_t   endPt,
    output logic     frameStart,
    output logic     load,
    output logic     rotate,
    output edgeIdx_t edgeIdx,
    output logic     frameDone,
    lineReqIf.sequencer line
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_FRAME_START,
        S_RELOAD,
        S_ISSUE,
        S_WAIT,
        S_ROTATE,
        S_FINISH
    } state_e;

    state_e   state;
    state_e   nextState;
    shape_e   prevShape;
    logic     firstFrame;
    vertIdx_t loadCnt;
    logic     needReload;

    // shape was latched by the library during idle
    assign needReload = firstFrame || (shape != prevShape);

    always_comb begin
        nextState = state;
        case (state)
            S_IDLE: begin
                nextState = S_FRAME_START;
            end
            S_FRAME_START: begin
                nextState = needReload ? S_RELOAD : S_ISSUE;
            end
            S_RELOAD: begin
                if (loadCnt == vertIdx_t'(`MAX_VERTS - 1)) begin
                    nextState = S_ISSUE;
                end
            end
            S_ISSUE: begin
                nextState = S_WAIT;
            end
            S_WAIT: begin
                if (line.done) begin
                    nextState = (edgeIdx == lastEdge) ? S_ROTATE : S_ISSUE;
                end
            end
            S_ROTATE: begin
                nextState = S_FINISH;
            end
            default: begin
                nextState = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= S_IDLE;
            prevShape <= SHAPE_TETRA;
            firstFrame <= 1'b1;
            loadCnt <= '0;
            edgeIdx <= '0;
        end else begin
            state <= nextState;
            case (state)
                S_FRAME_START: begin
                    prevShape <= shape;
                    firstFrame <= 1'b0;
                    loadCnt <= '0;
                    edgeIdx <= '0;
                end
                S_RELOAD: begin
                    loadCnt <= loadCnt + 1'b1;
                end
                S_WAIT: begin
                    // next request goes out the cycle after done
                    if (line.done && edgeIdx != lastEdge) begin
                        edgeIdx <= edgeIdx + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign frameStart = (state == S_IDLE);
    assign load = (state == S_RELOAD);
    assign rotate = (state == S_ROTATE);
    assign frameDone = (state == S_FINISH);

    // endpoints follow edgeIdx, so they hold while the line is drawn
    assign line.go = (state == S_ISSUE);
    assign line.startPt = startPt;
    assign line.endPt = endPt;
endmodule

// File: raster/lineRasterizer.sv
`timescale 1ns/1ps

module lineRasterizer
    import renderPkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    lineReqIf.rasterizer line,
    output pixel_t pixelX,
    output pixel_t pixelY,
    output logic   plot
);
    typedef enum logic [1:0] {
        R_IDLE,
        R_SETUP,
        R_DRAW,
        R_DONE
    } state_e;

    state_e state;
    pixel_t curX;
    pixel_t curY;
    pixel_t endX;
    pixel_t endY;
    pixel_t dx;
    pixel_t dy;
    logic   xLeft;
    logic signed [11:0] err;

    point_t firstPt;
    point_t lastPt;
    logic   inSetup;
    pixel_t spanDx;
    pixel_t spanDy;
    pixel_t useDx;
    pixel_t useDy;
    logic   useLeft;
    logic signed [11:0] dxW;
    logic signed [11:0] dyW;
    logic signed [11:0] errCur;
    logic signed [11:0] errTwice;
    logic   moveX;
    logic   moveY;
    logic   atEnd;

    // start at the smaller y so y only counts up
    always_comb begin
        if (line.endPt.y < line.startPt.y) begin
            firstPt = line.endPt;
            lastPt = line.startPt;
        end else begin
            firstPt = line.startPt;
            lastPt = line.endPt;
        end
    end

    // setup cycle works from the fresh deltas, later cycles from the registers
    assign inSetup = (state == R_SETUP);
    assign spanDx = (endX >= curX) ? endX - curX : curX - endX;
    assign spanDy = endY - curY;
    assign useDx = inSetup ? spanDx : dx;
    assign useDy = inSetup ? spanDy : dy;
    assign useLeft = inSetup ? (endX < curX) : xLeft;
    assign dxW = {3'b000, useDx};
    assign dyW = {3'b000, useDy};
    assign errCur = inSetup ? dxW - dyW : err;
    assign errTwice = errCur <<< 1;
    assign moveX = errTwice > -dyW;
    assign moveY = errTwice < dxW;
    assign atEnd = (curX == endX) && (curY == endY);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= R_IDLE;
        end else begin
            case (state)
                R_IDLE: begin
                    if (line.go) begin
                        state <= R_SETUP;
                    end
                end
                R_SETUP, R_DRAW: begin
                    state <= atEnd ? R_DONE : R_DRAW;
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_IDLE && line.go) begin
            curX <= firstPt.x;
            curY <= firstPt.y;
            endX <= lastPt.x;
            endY <= lastPt.y;
        end else if ((inSetup || state == R_DRAW) && !atEnd) begin
            if (moveX) begin
                curX <= useLeft ? curX - 1'b1 : curX + 1'b1;
            end
            if (moveY) begin
                curY <= curY + 1'b1;
            end
            err <= errCur - (moveX ? dyW : 12'sd0) + (moveY ? dxW : 12'sd0);
        end
        if (inSetup) begin
            dx <= spanDx;
            dy <= spanDy;
            xLeft <= endX < curX;
        end
    end

    assign pixelX = curX;
    assign pixelY = curY;
    assign plot = inSetup || (state == R_DRAW);
    assign line.done = (state == R_DONE);
endmodule

// File: source/wireframeRenderer.sv
`timescale 1ns/1ps

module wireframeRenderer
    import renderPkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic [1:0] shapeSelect,
    input  logic [2:0] colourIn,
    output logic [8:0] pixelX,
    output logic [8:0] pixelY,
    output logic [2:0] pixelColour,
    output logic       plot,
    output logic       frameDone
);
    shape_e   shape;
    colour_t  colour;
    vertex_t  baseVertex;
    edge_t    curEdge;
    edgeIdx_t lastEdge;
    edgeIdx_t edgeIdx;
    vertIdx_t loadIdx;
    point_t   startPt;
    point_t   endPt;
    logic     frameStart;
    logic     load;
    logic     rotate;

    lineReqIf lineBus ();

    shapeLibrary u_shapeLibrary (
        .clk        (clk),
        .resetn     (resetn),
        .shapeSelect(shapeSelect),
        .colourIn   (colourIn),
        .frameStart (frameStart),
        .vertIdx    (loadIdx),
        .edgeIdx    (edgeIdx),
        .shape      (shape),
        .colour     (colour),
        .baseVertex (baseVertex),
        .curEdge    (curEdge),
        .lastEdge   (lastEdge)
    );

    vertexRotator u_vertexRotator (
        .clk       (clk),
        .resetn    (resetn),
        .load      (load),
        .rotate    (rotate),
        .baseVertex(baseVertex),
        .curEdge   (curEdge),
        .loadIdx   (loadIdx),
        .startPt   (startPt),
        .endPt     (endPt)
    );

    edgeSequencer u_edgeSequencer (
        .clk       (clk),
        .resetn    (resetn),
        .shape     (shape),
        .lastEdge  (lastEdge),
        .startPt   (startPt),
        .endPt     (endPt),
        .frameStart(frameStart),
        .load      (load),
        .rotate    (rotate),
        .edgeIdx   (edgeIdx),
        .frameDone (frameDone),
        .line      (lineBus.sequencer)
    );

    lineRasterizer u_lineRasterizer (
        .clk   (clk),
        .resetn(resetn),
        .line  (lineBus.rasterizer),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .plot  (plot)
    );

    // colour sampled at frame start
    assign pixelColour = colour;
endmodule

// File: tests/wireframeRenderer_assert.sv
`timescale 1ns/1ps
`include "render_defs.svh"

module wireframeRenderer_assert
    import renderPkg::*;
(
    input logic   clk,
    input logic   resetn,
    input logic   go,
    input logic   done,
    input point_t startPt,
    input point_t endPt,
    input pixel_t pixelX,
    input pixel_t pixelY,
    input logic   plot
);
    // busy covers setup and draw (plot high) and the done cycle
    property goOnlyWhenIdle;
        @(posedge clk) disable iff (!resetn) go |-> !(plot || done);
    endproperty

    // request endpoints stay put from go until done
    property endpointsHeld;
        @(posedge clk) disable iff (!resetn)
            (plot || done) |-> ($stable(startPt) && $stable(endPt));
    endproperty

    // adapter only takes on-screen plots
    property plotOnScreen;
        @(posedge clk) disable iff (!resetn)
            plot |-> ((pixelX < `SCREEN_W) && (pixelY < `SCREEN_H));
    endproperty

    assert property (goOnlyWhenIdle)
        else $error("line request while the rasterizer is busy");
    assert property (endpointsHeld)
        else $error("line endpoints changed while the line was drawn");
    assert property (plotOnScreen)
        else $error("pixel plotted outside the screen");
endmodule

bind lineRasterizer wireframeRenderer_assert u_rasterAssert (
    .clk    (clk),
    .resetn (resetn),
    .go     (line.go),
    .done   (line.done),
    .startPt(line.startPt),
    .endPt  (line.endPt),
    .pixelX (pixelX),
    .pixelY (pixelY),
    .plot   (plot)
);

// File: tests/wireframeRenderer_tb.sv
`timescale 1ns/1ps
`include "render_defs.svh"

module wireframeRenderer_tb
    import renderPkg::*;
();
    localparam int NUM_FRAMES = 6;
    // one octahedron frame with a full-width line per edge, plus reload and handover
    localparam int FRAME_CYCLES = `MAX_EDGES * (`SCREEN_W + 8) + `MAX_VERTS + 8;
    localparam int CYCLE_LIMIT = 2 * NUM_FRAMES * FRAME_CYCLES + 40;

    logic       clk;
    logic       resetn;
    logic [1:0] shapeSelect;
    logic [2:0] colourIn;
    logic [8:0] pixelX;
    logic [8:0] pixelY;
    logic [2:0] pixelColour;
    logic       plot;
    logic       frameDone;

    int          errorCount;
    int          checkCount;
    int          cycleCount = 0;
    logic [31:0] lcgState;

    // reference model state
    vertex_t    modelBank [`MAX_VERTS];
    shape_e     modelShape;
    logic       modelLoaded;
    logic [1:0] frameSelect;
    colour_t    frameColour;
    logic [1:0] selectOrder [NUM_FRAMES + 1];
    colour_t    colourOrder [NUM_FRAMES + 1];
    point_t     expPixels [$];
    int         expCounts [$];

    int tetraEdges [6][2] = '{'{0, 1}, '{0, 2}, '{0, 3}, '{1, 2}, '{1, 3}, '{2, 3}};
    int octaEdges [12][2] = '{
        '{0, 2}, '{0, 3}, '{0, 4}, '{0, 5}, '{1, 2}, '{1, 3},
        '{1, 4}, '{1, 5}, '{2, 4}, '{2, 5}, '{3, 4}, '{3, 5}
    };

    wireframeRenderer u_wireframeRenderer (
        .clk        (clk),
        .resetn     (resetn),
        .shapeSelect(shapeSelect),
        .colourIn   (colourIn),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .pixelColour(pixelColour),
        .plot       (plot),
        .frameDone  (frameDone)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: the frames did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic comparePoint(input string what, input point_t got, input point_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t ns: %s is (%0d,%0d), expected (%0d,%0d)",
                     $time, what, got.x, got.y, exp.x, exp.y);
        end
    endtask

    task automatic compareColour(input string what, input colour_t got, input colour_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compareCount(input string what, input int got, input int exp);
        checkCount++;
        if (got != exp) begin
            errorCount++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic vertex_t baseVertexOf(shape_e s, int i);
        vertex_t v;
        coord_t  r;
        v = '0;
        if (s == SHAPE_OCTA) begin
            // axis i/2, positive pole first
            r = (i % 2 == 0) ? coord_t'(`OCTA_R) : coord_t'(-`OCTA_R);
            case (i / 2)
                0: v.x = r;
                1: v.y = r;
                default: v.z = r;
            endcase
        end else if (i < 4) begin
            v.x = (i < 2) ? coord_t'(`TETRA_R) : coord_t'(-`TETRA_R);
            v.y = (i == 0 || i == 2) ? coord_t'(`TETRA_R) : coord_t'(-`TETRA_R);
            v.z = (i == 0 || i == 3) ? coord_t'(`TETRA_R) : coord_t'(-`TETRA_R);
        end
        return v;
    endfunction

    task automatic rotateModel();
        int x;
        int y;
        int z;
        for (int i = 0; i < `MAX_VERTS; i++) begin
            x = int'(modelBank[i].x);
            y = int'(modelBank[i].y);
            z = int'(modelBank[i].z);
            modelBank[i].x = coord_t'((511 * x - 10 * y) >>> `ROT_SHIFT);
            modelBank[i].y = coord_t'((10 * x + 511 * y - 5 * z) >>> `ROT_SHIFT);
            modelBank[i].z = coord_t'((x + 5 * y + 512 * z) >>> `ROT_SHIFT);
        end
    endtask

    function automatic point_t projectModel(vertex_t v);
        point_t p;
        p.x = pixel_t'((int'(v.x) >>> `PROJ_SHIFT) + `CENTRE_X);
        p.y = pixel_t'((int'(v.y) >>> `PROJ_SHIFT) + `CENTRE_Y);
        return p;
    endfunction

    // Bresenham from the endpoint with the smaller y, startPt on a tie
    task automatic appendLine(input point_t a, input point_t b);
        point_t p;
        int     x0;
        int     y0;
        int     x1;
        int     y1;
        int     dx;
        int     dy;
        int     sx;
        int     err;
        int     e2;
        int     n;
        if (b.y < a.y) begin
            p = a;
            a = b;
            b = p;
        end
        x0 = int'(a.x);
        y0 = int'(a.y);
        x1 = int'(b.x);
        y1 = int'(b.y);
        dx = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy = y1 - y0;
        sx = (x1 < x0) ? -1 : 1;
        err = dx - dy;
        n = ((dx > dy) ? dx : dy) + 1;
        expCounts.push_back(n);
        for (int k = 0; k < n; k++) begin
            p.x = pixel_t'(x0);
            p.y = pixel_t'(y0);
            expPixels.push_back(p);
            e2 = 2 * err;
            if (e2 > -dy) begin
                err -= dy;
                x0 += sx;
            end
            if (e2 < dx) begin
                err += dx;
                y0 += 1;
            end
        end
    endtask

    task automatic buildFrame();
        int numEdges;
        int h;
        int t;
        expPixels.delete();
        expCounts.delete();
        numEdges = (modelShape == SHAPE_OCTA) ? 12 : 6;
        for (int e = 0; e < numEdges; e++) begin
            h = (modelShape == SHAPE_OCTA) ? octaEdges[e][0] : tetraEdges[e][0];
            t = (modelShape == SHAPE_OCTA) ? octaEdges[e][1] : tetraEdges[e][1];
            appendLine(projectModel(modelBank[h]), projectModel(modelBank[t]));
        end
    endtask

    // checks one frame and moves the inputs to the next frame's values after its first plot
    task automatic runFrame(input logic [1:0] nextSelect, input colour_t nextColour);
        shape_e s;
        int     run;
        int     lineNo;
        int     plots;
        logic   changed;
        logic   ended;
        point_t got;
        s = (frameSelect == 2'd1) ? SHAPE_OCTA : SHAPE_TETRA;
        if (!modelLoaded || s != modelShape) begin
            for (int i = 0; i < `MAX_VERTS; i++) begin
                modelBank[i] = baseVertexOf(s, i);
            end
        end
        modelShape = s;
        modelLoaded = 1'b1;
        buildFrame();
        run = 0;
        lineNo = 0;
        plots = 0;
        changed = 1'b0;
        ended = 1'b0;
        while (!ended) begin
            @(posedge clk);
            if (plots > 0 && !changed) begin
                shapeSelect <= nextSelect;
                colourIn <= nextColour;
                changed = 1'b1;
            end
            @(negedge clk);
            if (plot) begin
                got.x = pixelX;
                got.y = pixelY;
                if (expPixels.size() == 0) begin
                    errorCount++;
                    $display("more pixels plotted than the frame has, extra one at %0t ns", $time);
                end else begin
                    comparePoint("pixel", got, expPixels.pop_front());
                end
                compareColour("pixel colour", pixelColour, frameColour);
                run++;
                plots++;
            end else if (run > 0) begin
                compareCount("pixels in line", run, (lineNo < expCounts.size()) ? expCounts[lineNo] : 0);
                lineNo++;
                run = 0;
            end
            ended = frameDone;
        end
        compareCount("lines in frame", lineNo, expCounts.size());
        compareCount("pixels not plotted", expPixels.size(), 0);
        @(negedge clk);
        compareCount("frameDone after its pulse", int'(frameDone), 0);
        rotateModel();
        frameSelect = nextSelect;
        frameColour = nextColour;
    endtask

    task automatic checkReset();
        repeat (8) begin
            @(negedge clk);
            compareCount("plot in reset", int'(plot), 0);
            compareCount("frameDone in reset", int'(frameDone), 0);
        end
        @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        compareCount("plot after reset", int'(plot), 0);
        compareCount("frameDone after reset", int'(frameDone), 0);
    endtask

    // base frame, then once and twice rotated
    task automatic testTetraFrames();
        for (int k = 0; k < 3; k++) begin
            runFrame(selectOrder[k + 1], colourOrder[k + 1]);
        end
    endtask

    task automatic testOctaSwitch();
        for (int k = 3; k < NUM_FRAMES; k++) begin
            runFrame(selectOrder[k + 1], colourOrder[k + 1]);
        end
    endtask

    initial begin
        logic [31:0] r;
        clk = 1'b0;
        resetn = 1'b0;
        errorCount = 0;
        checkCount = 0;
        modelLoaded = 1'b0;
        modelShape = SHAPE_TETRA;
        lcgState = 32'ha3c0c836;
        // tetrahedron codes 0, 2 or 3 first, then two octahedron frames, then any shape
        for (int k = 0; k <= NUM_FRAMES; k++) begin
            r = nextRandom();
            if (k < 3) begin
                selectOrder[k] = (r[17:16] == 2'd1) ? 2'd3 : r[17:16];
            end else if (k < 5) begin
                selectOrder[k] = 2'd1;
            end else begin
                selectOrder[k] = r[17:16];
            end
            colourOrder[k] = r[26:24];
            if (k > 0 && colourOrder[k] == colourOrder[k - 1]) begin
                colourOrder[k] = colourOrder[k] + 1'b1;
            end
        end
        frameSelect = selectOrder[0];
        frameColour = colourOrder[0];
        shapeSelect = frameSelect;
        colourIn = frameColour;
        checkReset();
        testTetraFrames();
        testOctaSwitch();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end
endmodule

// File: compile.f
+incdir+common
common/renderPkg.sv
common/lineReqIf.sv
source/shapeLibrary.sv
source/vertexRotator.sv
source/edgeSequencer.sv
raster/lineRasterizer.sv
source/wireframeRenderer.sv
tests/wireframeRenderer_assert.sv
tests/wireframeRenderer_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= wireframeRenderer_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
